// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_oscilloscope
FILELIST = sim.f
BUILD    = obj_dir
BIN      = $(BUILD)/V$(TOP)
LOG      = sim.log
SOURCES := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@! grep -q "Simulation finished: FAIL" $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== logic/oscilloscope_top.sv ====
`default_nettype none

module oscilloscope_top (
    input  logic                           clk,
    input  logic                           rst,
    input  scope_pkg::mouse_t              mouse,
    input  logic [scope_pkg::SAMPLE_W-1:0] adc_sample,
    input  logic                           adc_valid,
    input  logic                           credit_return,
    output scope_pkg::scope_settings_t     settings,
    output scope_pkg::chart_offset_t       offset,
    output scope_pkg::trace_point_t        point,
    output logic                           point_valid
);

    logic                           wr_en;
    logic [scope_pkg::IDX_W-1:0]    wr_addr;
    logic [scope_pkg::SAMPLE_W-1:0] wr_data;
    logic                           capture_done;
    logic                           streaming;

    user_interface u_ui (
        .clk      (clk),
        .rst      (rst),
        .mouse    (mouse),
        .settings (settings),
        .offset   (offset)
    );

    trigger_capture u_capture (
        .clk          (clk),
        .rst          (rst),
        .adc_sample   (adc_sample),
        .adc_valid    (adc_valid),
        .settings     (settings),
        .streaming    (streaming),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .capture_done (capture_done)
    );

    trace_streamer u_streamer (
        .clk           (clk),
        .rst           (rst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .capture_done  (capture_done),
        .credit_return (credit_return),
        .point         (point),
        .point_valid   (point_valid),
        .streaming     (streaming)
    );

endmodule

`default_nettype wire

// ==== logic/scope_pkg.sv ====
`default_nettype none

package scope_pkg;

    //////////////////////////////
    // Sizes

    localparam int SAMPLE_W     = 12;
    localparam int TRACE_LEN    = 32;
    localparam int IDX_W        = $clog2(TRACE_LEN);
    localparam int CREDITS_INIT = 4;
    localparam int CREDIT_W     = $clog2(CREDITS_INIT + 1);

    // Button lockout after a step
    localparam int REPEAT_WAIT  = 16;

    //////////////////////////////
    // Screen regions on xpos

    localparam int ADC_X_LO  = 500;
    localparam int ADC_X_HI  = 1000;
    localparam int TRIG_X_LO = 100;

    // Chart window with inclusive edges
    localparam int CHART_X = 100;
    localparam int CHART_W = 400;
    localparam int CHART_Y = 100;
    localparam int CHART_H = 300;

    //////////////////////////////
    // Setting limits and reset values

    localparam int DECIM_MAX   = 15;
    localparam int HOLDOFF_MAX = 63;
    localparam int DECIM_RST   = 1;
    localparam int TRIG_RST    = 2048;
    localparam int HOLDOFF_RST = 2;

    //////////////////////////////
    // Types

    typedef struct packed {
        logic        left;
        logic        right;
        logic        middle;
        logic [11:0] xpos;
        logic [11:0] ypos;
    } mouse_t;

    typedef struct packed {
        logic [11:0] decimation;
        logic [11:0] trig_level;
        logic [11:0] holdoff;
    } scope_settings_t;

    // Minus bits set when pointer is at/left of or at/above the anchor
    typedef struct packed {
        logic [10:0] dx;
        logic [10:0] dy;
        logic        minus_x;
        logic        minus_y;
    } chart_offset_t;

    typedef struct packed {
        logic [IDX_W-1:0]    index;
        logic [SAMPLE_W-1:0] sample;
    } trace_point_t;

endpackage

`default_nettype wire

// ==== logic/trace_streamer.sv ====
`default_nettype none

module trace_streamer (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_en,
    input  logic [scope_pkg::IDX_W-1:0]    wr_addr,
    input  logic [scope_pkg::SAMPLE_W-1:0] wr_data,
    input  logic                           capture_done,
    input  logic                           credit_return,
    output scope_pkg::trace_point_t        point,
    output logic                           point_valid,
    output logic                           streaming
);
    import scope_pkg::*;

    logic [SAMPLE_W-1:0] trace_mem [TRACE_LEN];
    logic [IDX_W-1:0]    rd_idx;
    logic [CREDIT_W-1:0] credits;
    logic                send;

    // One point per cycle while a credit is left
    assign send = streaming && (credits != '0);

    //////////////////////////////
    // Trace buffer

    always_ff @(posedge clk) begin
        if (wr_en) begin
            trace_mem[wr_addr] <= wr_data;
        end
    end

    //////////////////////////////
    // Readout

    always_ff @(posedge clk) begin
        if (rst) begin
            streaming   <= 1'b0;
            rd_idx      <= '0;
            point_valid <= 1'b0;
        end else begin
            point_valid <= send;
            if (capture_done) begin
                streaming <= 1'b1;
                rd_idx    <= '0;
            end else if (send) begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == IDX_W'(TRACE_LEN - 1)) begin
                    streaming <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            point.index  <= rd_idx;
            point.sample <= trace_mem[rd_idx];
        end
    end

    //////////////////////////////
    // Credit counter

    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CREDIT_W'(CREDITS_INIT);
        end else begin
            case ({send, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                // Send and return together cancel out
                default: credits <= credits;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/trigger_capture.sv ====
`default_nettype none

module trigger_capture (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [scope_pkg::SAMPLE_W-1:0] adc_sample,
    input  logic                           adc_valid,
    input  scope_pkg::scope_settings_t     settings,
    input  logic                           streaming,
    output logic                           wr_en,
    output logic [scope_pkg::IDX_W-1:0]    wr_addr,
    output logic [scope_pkg::SAMPLE_W-1:0] wr_data,
    output logic                           capture_done
);
    import scope_pkg::*;

    typedef enum logic [1:0] {
        CAP_ARMED,
        CAP_RUN,
        CAP_HOLDOFF
    } cap_state_t;

    cap_state_t          state;
    logic [11:0]         keep_cnt;
    logic [SAMPLE_W-1:0] prev_sample;
    logic [IDX_W-1:0]    wr_idx;
    logic [11:0]         hold_cnt;
    logic                kept;
    logic                trig_hit;
    logic                write_now;

    //////////////////////////////
    // Decimation and crossing

    assign kept      = adc_valid && (keep_cnt == '0);
    assign trig_hit  = kept && (state == CAP_ARMED) &&
                       (prev_sample < settings.trig_level) &&
                       (adc_sample >= settings.trig_level);
    assign write_now = trig_hit || (kept && (state == CAP_RUN));

    always_ff @(posedge clk) begin
        if (rst) begin
            keep_cnt <= '0;
        end else if (adc_valid) begin
            keep_cnt <= (keep_cnt >= settings.decimation) ? '0 : keep_cnt + 12'd1;
        end
    end

    // All ones so the first kept sample can never cross
    always_ff @(posedge clk) begin
        if (rst) begin
            prev_sample <= '1;
        end else if (kept) begin
            prev_sample <= adc_sample;
        end
    end

    //////////////////////////////
    // Capture FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= CAP_ARMED;
            wr_idx   <= '0;
            hold_cnt <= '0;
        end else begin
            case (state)
                CAP_ARMED: begin
                    if (trig_hit) begin
                        state  <= CAP_RUN;
                        wr_idx <= IDX_W'(1);
                    end
                end
                CAP_RUN: begin
                    if (kept) begin
                        // Index wraps back to zero on the last write
                        wr_idx <= wr_idx + 1'b1;
                        if (wr_idx == IDX_W'(TRACE_LEN - 1)) begin
                            state    <= CAP_HOLDOFF;
                            hold_cnt <= '0;
                        end
                    end
                end
                CAP_HOLDOFF: begin
                    // Count only kept samples after capture_done
                    if (capture_done) begin
                        hold_cnt <= '0;
                    end else if (hold_cnt >= settings.holdoff) begin
                        if (!wr_en && !streaming) begin
                            state <= CAP_ARMED;
                        end
                    end else if (kept) begin
                        hold_cnt <= hold_cnt + 12'd1;
                    end
                end
                default: state <= CAP_ARMED;
            endcase
        end
    end

    //////////////////////////////
    // Buffer write port

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_en        <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            wr_en        <= write_now;
            capture_done <= wr_en && (wr_addr == IDX_W'(TRACE_LEN - 1));
        end
    end

    // wr_idx sits at zero while armed
    always_ff @(posedge clk) begin
        wr_addr <= wr_idx;
        wr_data <= adc_sample;
    end

endmodule

`default_nettype wire

// ==== logic/user_interface.sv ====
`default_nettype none

module user_interface (
    input  logic                       clk,
    input  logic                       rst,
    input  scope_pkg::mouse_t          mouse,
    output scope_pkg::scope_settings_t settings,
    output scope_pkg::chart_offset_t   offset
);
    import scope_pkg::*;

    localparam int WAIT_W = $clog2(REPEAT_WAIT);

    typedef enum logic {
        UI_IDLE,
        UI_WAIT
    } ui_state_t;

    ui_state_t         state;
    logic [WAIT_W-1:0] wait_cnt;
    logic              in_adc;
    logic              in_trig;
    logic              in_hold;
    logic              dec_up;
    logic              dec_dn;
    logic              trig_up;
    logic              trig_dn;
    logic              hold_up;
    logic              hold_dn;
    logic              accept;
    logic              in_chart;
    logic [11:0]       anchor_x;
    logic [11:0]       anchor_y;
    logic [11:0]       dist_x;
    logic [11:0]       dist_y;

    // One step toward max or zero that holds at either end
    function automatic logic [11:0] step(input logic [11:0] value, input logic up,
                                         input logic [11:0] max_value);
        if (up) begin
            return (value < max_value) ? value + 12'd1 : value;
        end
        return (value != 12'd0) ? value - 12'd1 : value;
    endfunction

    //////////////////////////////
    // Button decode

    assign in_adc  = (mouse.xpos > ADC_X_LO) && (mouse.xpos < ADC_X_HI);
    assign in_trig = (mouse.xpos > TRIG_X_LO) && (mouse.xpos < ADC_X_LO);
    assign in_hold = mouse.xpos < TRIG_X_LO;

    assign dec_up  = mouse.middle && mouse.right && in_adc;
    assign dec_dn  = mouse.middle && mouse.left && in_adc;
    assign trig_up = mouse.middle && mouse.right && in_trig;
    assign trig_dn = mouse.middle && mouse.left && in_trig;
    // Holdoff wants a single button
    assign hold_up = mouse.right && !mouse.left && !mouse.middle && in_hold;
    assign hold_dn = mouse.left && !mouse.right && !mouse.middle && in_hold;

    assign accept = dec_up || dec_dn || trig_up || trig_dn || hold_up || hold_dn;

    //////////////////////////////
    // Settings FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= UI_IDLE;
            wait_cnt <= '0;
            settings <= '{decimation: 12'(DECIM_RST),
                          trig_level: 12'(TRIG_RST),
                          holdoff:    12'(HOLDOFF_RST)};
        end else begin
            case (state)
                UI_IDLE: begin
                    if (dec_up || dec_dn) begin
                        settings.decimation <= step(settings.decimation, dec_up,
                                                    12'(DECIM_MAX));
                    end else if (trig_up || trig_dn) begin
                        settings.trig_level <= step(settings.trig_level, trig_up, '1);
                    end else if (hold_up || hold_dn) begin
                        settings.holdoff <= step(settings.holdoff, hold_up,
                                                 12'(HOLDOFF_MAX));
                    end
                    // Clamped steps still lock the buttons out
                    if (accept) begin
                        state    <= UI_WAIT;
                        wait_cnt <= '0;
                    end
                end
                UI_WAIT: begin
                    if (wait_cnt == WAIT_W'(REPEAT_WAIT - 1)) begin
                        state <= UI_IDLE;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                default: state <= UI_IDLE;
            endcase
        end
    end

    //////////////////////////////
    // Chart drag

    assign in_chart = (mouse.xpos >= CHART_X) && (mouse.xpos <= CHART_X + CHART_W) &&
                      (mouse.ypos >= CHART_Y) && (mouse.ypos <= CHART_Y + CHART_H);

    assign dist_x = (anchor_x >= mouse.xpos) ? anchor_x - mouse.xpos : mouse.xpos - anchor_x;
    assign dist_y = (anchor_y >= mouse.ypos) ? anchor_y - mouse.ypos : mouse.ypos - anchor_y;

    always_ff @(posedge clk) begin
        if (rst) begin
            anchor_x <= '0;
            anchor_y <= '0;
            offset   <= '0;
        end else if (!in_chart) begin
            // Anchor tracks the pointer until it enters the chart
            anchor_x <= mouse.xpos;
            anchor_y <= mouse.ypos;
        end else if (mouse.left) begin
            offset.dx      <= dist_x[10:0];
            offset.dy      <= dist_y[10:0];
            offset.minus_x <= anchor_x >= mouse.xpos;
            offset.minus_y <= anchor_y >= mouse.ypos;
        end
    end

endmodule

`default_nettype wire

// ==== sim.f ====
logic/scope_pkg.sv
logic/user_interface.sv
logic/trigger_capture.sv
logic/trace_streamer.sv
logic/oscilloscope_top.sv
test/tb_oscilloscope.sv

// ==== test/tb_oscilloscope.sv ====
`default_nettype none

module tb_oscilloscope;
    import scope_pkg::*;

    localparam int NUM_PRESSES     = 110;
    localparam int PRESS_CYCLES    = REPEAT_WAIT + 4;
    localparam int NUM_TRACES      = 9;
    localparam int TRACE_BUDGET    = 800;
    localparam int OTHER_CYCLES    = 300;
    localparam int STIM_CYCLES     = NUM_PRESSES * PRESS_CYCLES + NUM_TRACES * TRACE_BUDGET
                                     + OTHER_CYCLES;
    localparam int WATCHDOG_CYCLES = 4 * (STIM_CYCLES + 32 * NUM_TRACES * TRACE_LEN);

    logic                clk;
    logic                rst;
    mouse_t              mouse;
    logic [SAMPLE_W-1:0] adc_sample;
    logic                adc_valid;
    logic                credit_return;
    scope_settings_t     settings;
    chart_offset_t       offset;
    trace_point_t        point;
    logic                point_valid;

    // Model state
    scope_settings_t exp_set;
    chart_offset_t   exp_off;
    int              anchor_x;
    int              anchor_y;
    int              applied[$];
    trace_point_t    exp_q[$];

    // Consumer state
    int rcv_cnt;
    int returned;
    int held_pts;
    int stall_left;
    int credit_mode;

    oscilloscope_top UUT (
        .clk           (clk),
        .rst           (rst),
        .mouse         (mouse),
        .adc_sample    (adc_sample),
        .adc_valid     (adc_valid),
        .credit_return (credit_return),
        .settings      (settings),
        .offset        (offset),
        .point         (point),
        .point_valid   (point_valid)
    );

    always #2 clk = ~clk;

    //////////////////////////////
    // Failure reporting and compares

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped after a failed check");
    endtask

    task automatic check_settings(input scope_settings_t got, input scope_settings_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("Fail settings: got %h, expected %h", got, want));
        end
    endtask

    task automatic check_offset(input chart_offset_t got, input chart_offset_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("Fail offset: got %h, expected %h", got, want));
        end
    endtask

    task automatic check_point(input trace_point_t got, input trace_point_t want);
        if (got !== want) begin
            stop_with_failure($sformatf("Fail point: got %h, expected %h", got, want));
        end
    endtask

    //////////////////////////////
    // Reference models

    function automatic logic [11:0] clamp_field(input int v, input int hi);
        if (v < 0) begin
            return 12'd0;
        end
        if (v > hi) begin
            return 12'(hi);
        end
        return 12'(v);
    endfunction

    // Rule order decides which field a button combination steps
    function automatic scope_settings_t apply_press(input scope_settings_t s, input logic l,
                                                    input logic r, input logic m, input int x);
        scope_settings_t n;
        int              dir;
        n = s;
        dir = r ? 1 : -1;
        if (m && (l || r) && x > ADC_X_LO && x < ADC_X_HI) begin
            n.decimation = clamp_field(int'(s.decimation) + dir, DECIM_MAX);
        end else if (m && (l || r) && x > TRIG_X_LO && x < ADC_X_LO) begin
            n.trig_level = clamp_field(int'(s.trig_level) + dir, 4095);
        end else if (!m && (l != r) && x < TRIG_X_LO) begin
            n.holdoff = clamp_field(int'(s.holdoff) + dir, HOLDOFF_MAX);
        end
        return n;
    endfunction

    function automatic chart_offset_t drag_offset(input int ax, input int ay, input int x,
                                                  input int y);
        chart_offset_t o;
        o.minus_x = (ax >= x);
        o.minus_y = (ay >= y);
        o.dx      = 11'(o.minus_x ? ax - x : x - ax);
        o.dy      = 11'(o.minus_y ? ay - y : y - ay);
        return o;
    endfunction

    // Rebuilds the expected points and returns how many belong to complete traces
    function automatic int build_trace(input int decim, input int level, input int hold);
        int           state;
        int           prev;
        int           wr;
        int           hcnt;
        int           s;
        int           i;
        trace_point_t p;
        exp_q.delete();
        state = 0;
        prev  = -1;
        wr    = 0;
        hcnt  = 0;
        for (i = 0; i < applied.size(); i++) begin
            if (i % (decim + 1) == 0) begin
                s = applied[i];
                if (state == 0 && prev >= 0 && prev < level && s >= level) begin
                    state = 1;
                    wr    = 0;
                end else if (state == 2) begin
                    hcnt++;
                    if (hcnt >= hold) begin
                        state = 0;
                    end
                end
                if (state == 1) begin
                    p.index  = 5'(wr);
                    p.sample = 12'(s);
                    exp_q.push_back(p);
                    wr++;
                    if (wr == TRACE_LEN) begin
                        state = (hold == 0) ? 0 : 2;
                        hcnt  = 0;
                    end
                end
                prev = s;
            end
        end
        return (exp_q.size() / TRACE_LEN) * TRACE_LEN;
    endfunction

    //////////////////////////////
    // Stimulus helpers

    function automatic mouse_t make_mouse(input logic l, input logic r, input logic m,
                                          input int x, input int y);
        mouse_t ms;
        ms.left   = l;
        ms.right  = r;
        ms.middle = m;
        ms.xpos   = 12'(x);
        ms.ypos   = 12'(y);
        return ms;
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        rst       <= 1'b1;
        adc_valid <= 1'b0;
        mouse     <= '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        exp_set = '{decimation: 12'(DECIM_RST), trig_level: 12'(TRIG_RST),
                    holdoff: 12'(HOLDOFF_RST)};
        exp_off = '0;
        applied.delete();
        exp_q.delete();
    endtask

    // Pointer kept at y=50 so the chart never sees the buttons
    task automatic press(input int count, input logic l, input logic r, input logic m,
                         input int x);
        repeat (count) begin
            @(posedge clk);
            mouse <= make_mouse(l, r, m, x, 50);
            @(posedge clk);
            mouse <= make_mouse(1'b0, 1'b0, 1'b0, x, 50);
            exp_set = apply_press(exp_set, l, r, m, x);
            @(negedge clk);
            check_settings(settings, exp_set);
            repeat (REPEAT_WAIT + 2) @(posedge clk);
        end
    endtask

    task automatic move_pointer(input logic l, input int x, input int y);
        @(posedge clk);
        mouse <= make_mouse(l, 1'b0, 1'b0, x, y);
        if (x < CHART_X || x > CHART_X + CHART_W || y < CHART_Y || y > CHART_Y + CHART_H) begin
            anchor_x = x;
            anchor_y = y;
        end else if (l) begin
            exp_off = drag_offset(anchor_x, anchor_y, x, y);
        end
        @(posedge clk);
        @(negedge clk);
        check_offset(offset, exp_off);
    endtask

    // Pauses samples after each finished trace until all its points arrive
    task automatic run_capture(input int traces, input int mode);
        int done_pts;
        int cycles;
        int n;
        int v;
        credit_mode = mode;
        done_pts    = 0;
        cycles      = 0;
        while (done_pts < traces * TRACE_LEN) begin
            if (cycles >= traces * TRACE_BUDGET) begin
                stop_with_failure("No complete trace was captured within the sample budget");
            end
            @(posedge clk);
            cycles++;
            if ($urandom_range(0, 3) == 0) begin
                adc_valid <= 1'b0;
            end else begin
                v = $urandom_range(0, 4095);
                adc_valid  <= 1'b1;
                adc_sample <= 12'(v);
                applied.push_back(v);
                n = build_trace(int'(exp_set.decimation), int'(exp_set.trig_level),
                                int'(exp_set.holdoff));
                if (n > done_pts) begin
                    done_pts = n;
                    @(posedge clk);
                    adc_valid <= 1'b0;
                    while (rcv_cnt < done_pts) begin
                        @(posedge clk);
                    end
                end
            end
        end
        @(posedge clk);
        adc_valid <= 1'b0;
    endtask

    //////////////////////////////
    // Display consumer and point monitor

    always @(posedge clk) begin
        if (rst) begin
            rcv_cnt       <= 0;
            returned      <= 0;
            stall_left    <= 0;
            credit_return <= 1'b0;
        end else begin
            if (point_valid) begin
                if (rcv_cnt >= CREDITS_INIT + returned) begin
                    stop_with_failure("A point arrived without a granted credit");
                end
                if (rcv_cnt >= exp_q.size()) begin
                    stop_with_failure("A point arrived when no trace was expected");
                end
                check_point(point, exp_q[rcv_cnt]);
                rcv_cnt <= rcv_cnt + 1;
            end
            held_pts = rcv_cnt + (point_valid ? 1 : 0) - returned;
            if (stall_left > 0) begin
                stall_left    <= stall_left - 1;
                credit_return <= 1'b0;
            end else if (held_pts > 0 && (credit_mode == 0 || $urandom_range(0, 1) == 1)) begin
                credit_return <= 1'b1;
                returned      <= returned + 1;
            end else begin
                credit_return <= 1'b0;
                // Long stretches without credits
                if (credit_mode == 1 && $urandom_range(0, 15) == 0) begin
                    stall_left <= $urandom_range(10, 40);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_with_failure("Timeout: the run did not finish in the expected number of cycles");
    end

    //////////////////////////////
    // Test sequence

    initial begin
        void'($urandom(76));
        clk           = 1'b0;
        rst           = 1'b1;
        mouse         = '0;
        adc_sample    = '0;
        adc_valid     = 1'b0;
        credit_return = 1'b0;
        credit_mode   = 0;
        anchor_x      = 0;
        anchor_y      = 0;
        exp_off       = '0;
        exp_set = '{decimation: 12'(DECIM_RST), trig_level: 12'(TRIG_RST),
                    holdoff: 12'(HOLDOFF_RST)};
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        // Reset values and a quiet output
        @(negedge clk);
        check_settings(settings, exp_set);
        check_offset(offset, exp_off);
        repeat (40) @(posedge clk);

        // Decimation down to 0, up to DECIM_MAX and clamped there
        press(2, 1'b1, 1'b0, 1'b1, 700);
        press(16, 1'b0, 1'b1, 1'b1, 700);
        press(1, 1'b1, 1'b1, 1'b1, 700);
        // Region edges and lone buttons do nothing
        press(1, 1'b0, 1'b1, 1'b1, 500);
        press(1, 1'b0, 1'b1, 1'b0, 700);
        press(1, 1'b0, 1'b1, 1'b1, 1000);
        press(1, 1'b0, 1'b1, 1'b1, 300);
        press(1, 1'b1, 1'b0, 1'b1, 300);
        press(1, 1'b1, 1'b1, 1'b1, 300);
        press(1, 1'b0, 1'b1, 1'b0, 50);
        press(4, 1'b1, 1'b0, 1'b0, 50);
        press(1, 1'b1, 1'b1, 1'b0, 50);
        press(1, 1'b0, 1'b1, 1'b1, 50);
        press(1, 1'b0, 1'b1, 1'b0, 100);
        press(64, 1'b0, 1'b1, 1'b0, 50);
        check_offset(offset, exp_off);

        // Chart drag
        move_pointer(1'b0, 600, 450);
        move_pointer(1'b0, 50, 50);
        move_pointer(1'b1, 300, 200);
        move_pointer(1'b1, 100, 100);
        move_pointer(1'b1, 500, 400);
        move_pointer(1'b0, 350, 250);
        move_pointer(1'b0, 300, 50);
        move_pointer(1'b1, 300, 120);
        move_pointer(1'b0, 600, 450);
        move_pointer(1'b1, 450, 380);
        move_pointer(1'b0, 450, 380);
        check_settings(settings, exp_set);

        // Captures at reset settings with prompt credits
        apply_reset();
        run_capture(2, 0);

        // Decimation 3 under back-pressure
        apply_reset();
        press(2, 1'b0, 1'b1, 1'b1, 700);
        press(1, 1'b1, 1'b0, 1'b1, 300);
        run_capture(2, 1);

        // Holdoff 6 and rearm
        apply_reset();
        press(4, 1'b0, 1'b1, 1'b0, 50);
        press(1, 1'b0, 1'b1, 1'b1, 700);
        run_capture(3, 1);

        // Holdoff 0 rearms at once
        apply_reset();
        press(2, 1'b1, 1'b0, 1'b0, 50);
        run_capture(2, 0);

        // Quiet tail where the monitor still catches any stray point
        repeat (60) @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
